/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - hdl/mem_stage_pkg.sv
      - hdl/ex_mem_latch.sv
      - hdl/store_align.sv
      - hdl/load_extract.sv
      - hdl/axi_data_port.sv
      - hdl/wb_select.sv
      - hdl/mem_stage.sv
  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/tb_mem_stage.sv

/* build.f */
hdl/mem_stage_pkg.sv
hdl/ex_mem_latch.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/axi_data_port.sv
hdl/wb_select.sv
hdl/mem_stage.sv
testbench/axi_mem_model.sv
testbench/tb_mem_stage.sv

/* hdl/axi_data_port.sv */
// single-beat AXI4 master for the memory stage
// issues one read or one write per latched load/store, waits for the response
// and holds mem_done plus the read beat until the stage advances
`timescale 1ns/1ns

module axi_data_port
    import mem_stage_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            cur_valid,
    input  op_class_t       cur_op,
    input  logic [xlen-1:0] addr,
    input  axi_w_t          w_in,
    input  logic            advance,
    output logic            mem_done,
    output logic [xlen-1:0] rd_beat,
    output axi_addr_t       ar,
    output logic            arvalid,
    input  logic            arready,
    input  axi_r_t          r,
    input  logic            rvalid,
    output logic            rready,
    output axi_addr_t       aw,
    output logic            awvalid,
    input  logic            awready,
    output axi_w_t          w,
    output logic            wvalid,
    input  logic            wready,
    input  logic [1:0]      b_resp,
    input  logic            bvalid,
    output logic            bready
);
    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_done
    } port_state_t;

    port_state_t state;
    logic        wr_op;
    logic        start;
    logic        is_store;
    logic        ar_pend;
    logic        aw_pend;
    logic        w_pend;
    axi_addr_t   req;

    assign is_store = (cur_op == op_store);
    assign start    = cur_valid && ((cur_op == op_load) || is_store);

    // beat-aligned address, strobes pick the bytes
    assign req.addr  = {addr[axi_addr_w-1:3], 3'b000};
    assign req.len   = axi_len_single;
    assign req.size  = axi_size_8b;
    assign req.burst = axi_burst_incr;

    // still waiting on a ready after this cycle
    assign ar_pend = arvalid && !arready;
    assign aw_pend = awvalid && !awready;
    assign w_pend  = wvalid && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            wr_op   <= 1'b0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        wr_op   <= is_store;
                        arvalid <= !is_store;
                        awvalid <= is_store;
                        wvalid  <= is_store;
                        state   <= st_addr;
                    end
                end
                st_addr: begin
                    // aw and w may be taken in different cycles
                    arvalid <= ar_pend;
                    awvalid <= aw_pend;
                    wvalid  <= w_pend;
                    if (!ar_pend && !aw_pend && !w_pend) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    // b_resp and r.resp are not checked
                    if (wr_op ? bvalid : rvalid) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (advance) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // request payload frozen at issue, read beat held until advance
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            ar <= req;
            aw <= req;
            w  <= w_in;
        end
        if (state == st_resp && !wr_op && rvalid) begin
            rd_beat <= r.data;
        end
    end

    assign rready   = (state == st_resp) && !wr_op;
    assign bready   = (state == st_resp) && wr_op;
    assign mem_done = (state == st_done);

endmodule

/* hdl/ex_mem_latch.sv */
// input register of the memory stage
// takes one execute record under valid/ready, holds it while the stage stalls,
// and forwards the write-back result into the store source
`timescale 1ns/1ns

module ex_mem_latch
    import mem_stage_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  ex_mem_t         in_rec,
    input  logic            advance,
    input  gpr_write_t      wb_fwd,
    output logic            cur_valid,
    output ex_mem_t         cur_rec,
    output logic [xlen-1:0] store_src
);
    logic fwd_hit;
    logic take;

    // room when empty or the held record leaves this cycle
    assign in_ready = !cur_valid || advance;
    assign take     = in_ready && in_valid;

    // write-back is writing the register this record reads as rs2
    // x0 never forwards
    assign fwd_hit = wb_fwd.wen && (wb_fwd.rd == cur_rec.rs2) && (cur_rec.rs2 != '0);

    assign store_src = fwd_hit ? wb_fwd.value : cur_rec.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_valid <= 1'b0;
        end else if (in_ready) begin
            // drops to zero when advancing with nothing behind
            cur_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur_rec <= in_rec;
        end else if (fwd_hit) begin
            // fold the forwarded value in so it survives a stall
            // past the one-cycle write-back pulse
            cur_rec.src2 <= wb_fwd.value;
        end
    end

endmodule

/* hdl/load_extract.sv */
// load data extraction from a 64-bit read beat
// shifts the addressed field down and sign- or zero-extends it by funct3
`timescale 1ns/1ns

module load_extract
    import mem_stage_pkg::*;
(
    input  logic [2:0]      addr_low,
    input  size_code        funct3,
    input  logic [xlen-1:0] beat,
    output logic [xlen-1:0] load_value
);
    logic [xlen-1:0] shifted;
    logic            sign_ext;

    // addressed byte lands in bits 7:0
    assign shifted = beat >> {addr_low, 3'b000};

    // LB/LH/LW extend the sign, LBU/LHU/LWU do not
    assign sign_ext = !funct3[f3_unsigned_bit];

    always_comb begin
        case (funct3[1:0])
            sz_byte: begin
                load_value = {{(xlen-8){sign_ext & shifted[7]}}, shifted[7:0]};
            end
            sz_half: begin
                load_value = {{(xlen-16){sign_ext & shifted[15]}}, shifted[15:0]};
            end
            sz_word: begin
                load_value = {{(xlen-32){sign_ext & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                // LD, nothing to extend
                load_value = beat;
            end
        endcase
    end

endmodule

/* hdl/mem_stage.sv */
// memory-access stage of the RV64I pipeline, top level
// input latch, store lane placement, load extraction, AXI4 data port
// and write-back output wired together
`timescale 1ns/1ns

module mem_stage
    import mem_stage_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  ex_mem_t              in_rec,
    input  gpr_write_t           wb_fwd,
    output logic                 out_valid,
    input  logic                 out_ready,
    output mem_wb_t              out_rec,
    output gpr_write_t           gpr_wr,
    output logic                 mem_busy_wr,
    output logic [reg_idx_w-1:0] mem_rd,
    output axi_addr_t            ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  axi_r_t               r,
    input  logic                 rvalid,
    output logic                 rready,
    output axi_addr_t            aw,
    output logic                 awvalid,
    input  logic                 awready,
    output axi_w_t               w,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic [1:0]           b_resp,
    input  logic                 bvalid,
    output logic                 bready
);
    logic            cur_valid;
    ex_mem_t         cur_rec;
    logic [xlen-1:0] store_src;
    logic            advance;
    axi_w_t          w_aligned;
    logic            mem_done;
    logic [xlen-1:0] rd_beat;
    logic [xlen-1:0] load_value;

    ex_mem_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_rec    (in_rec),
        .advance   (advance),
        .wb_fwd    (wb_fwd),
        .cur_valid (cur_valid),
        .cur_rec   (cur_rec),
        .store_src (store_src)
    );

    // low address bits pick lanes on both store and load paths
    store_align u_store_align (
        .addr_low (cur_rec.alu_out[2:0]),
        .funct3   (cur_rec.funct3),
        .src      (store_src),
        .w_beat   (w_aligned)
    );

    load_extract u_load_extract (
        .addr_low   (cur_rec.alu_out[2:0]),
        .funct3     (cur_rec.funct3),
        .beat       (rd_beat),
        .load_value (load_value)
    );

    axi_data_port u_axi_port (
        .clk       (clk),
        .rst       (rst),
        .cur_valid (cur_valid),
        .cur_op    (cur_rec.op),
        .addr      (cur_rec.alu_out),
        .w_in      (w_aligned),
        .advance   (advance),
        .mem_done  (mem_done),
        .rd_beat   (rd_beat),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b_resp    (b_resp),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    wb_select u_wb_select (
        .cur_valid   (cur_valid),
        .cur_rec     (cur_rec),
        .mem_done    (mem_done),
        .load_value  (load_value),
        .store_src   (store_src),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_rec     (out_rec),
        .gpr_wr      (gpr_wr),
        .advance     (advance),
        .mem_busy_wr (mem_busy_wr),
        .mem_rd      (mem_rd)
    );

endmodule

/* hdl/mem_stage_pkg.sv */
// shared widths, operation classes, size codes and records for the memory stage
// imported by every module of the stage and by the testbench
package mem_stage_pkg;

    // datapath and bus widths
    localparam int xlen       = 64;
    localparam int axi_addr_w = 32;
    localparam int reg_idx_w  = 5;
    localparam int strb_w     = xlen / 8;

    // access size, low two bits of funct3
    localparam logic [1:0] sz_byte  = 2'd0;
    localparam logic [1:0] sz_half  = 2'd1;
    localparam logic [1:0] sz_word  = 2'd2;
    localparam logic [1:0] sz_dword = 2'd3;

    // funct3 bit 2 set means zero-extend
    localparam int f3_unsigned_bit = 2;

    // fixed single-beat AXI transfer: one beat, 8 bytes, INCR
    localparam logic [7:0] axi_len_single = 8'd0;
    localparam logic [2:0] axi_size_8b    = 3'd3;
    localparam logic [1:0] axi_burst_incr = 2'b01;

    // what the stage does with a record
    typedef enum logic [2:0] {
        op_none,
        op_alu,
        op_load,
        op_store,
        op_pass
    } op_class_t;

    // RV64 load/store funct3
    typedef logic [2:0] size_code;

    // record from execute
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [31:0]          inst;
        op_class_t            op;
        size_code             funct3;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs2;
        // effective address for loads and stores
        logic [xlen-1:0]      alu_out;
        logic [xlen-1:0]      src2;
    } ex_mem_t;

    // record to write-back
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [31:0]          inst;
        op_class_t            op;
        logic [reg_idx_w-1:0] rd;
    } mem_wb_t;

    // register-file write, also the write-back forwarding input
    typedef struct packed {
        logic                 wen;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      value;
    } gpr_write_t;

    typedef struct packed {
        logic [axi_addr_w-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_addr_t;

    typedef struct packed {
        logic [xlen-1:0]   data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [1:0]      resp;
        logic            last;
    } axi_r_t;

endpackage

/* hdl/store_align.sv */
// store data lane placement for a 64-bit data bus
// replicates the store value across the beat and builds the byte strobe
// from the access size and the low address bits
`timescale 1ns/1ns

module store_align
    import mem_stage_pkg::*;
(
    input  logic [2:0]      addr_low,
    input  size_code        funct3,
    input  logic [xlen-1:0] src,
    output axi_w_t          w_beat
);
    logic [strb_w-1:0] strb;
    logic [xlen-1:0]   data;

    always_comb begin
        case (funct3[1:0])
            sz_byte: begin
                // every lane carries the byte, strobe picks one
                data = {8{src[7:0]}};
                strb = 8'b0000_0001 << addr_low;
            end
            sz_half: begin
                data = {4{src[15:0]}};
                strb = 8'b0000_0011 << {addr_low[2:1], 1'b0};
            end
            sz_word: begin
                data = {2{src[31:0]}};
                strb = 8'b0000_1111 << {addr_low[2], 2'b00};
            end
            default: begin
                // double-word, whole beat
                data = src;
                strb = 8'hff;
            end
        endcase
    end

    assign w_beat.data = data;
    assign w_beat.strb = strb;
    // single-beat bursts only
    assign w_beat.last = 1'b1;

endmodule

/* hdl/wb_select.sv */
// output side of the memory stage
// drives the write-back handshake and the register-file write port,
// generates advance and reports the pending destination for interlock
`timescale 1ns/1ns

module wb_select
    import mem_stage_pkg::*;
(
    input  logic            cur_valid,
    input  ex_mem_t         cur_rec,
    input  logic            mem_done,
    input  logic [xlen-1:0] load_value,
    input  logic [xlen-1:0] store_src,
    output logic            out_valid,
    input  logic            out_ready,
    output mem_wb_t         out_rec,
    output gpr_write_t      gpr_wr,
    output logic            advance,
    output logic                 mem_busy_wr,
    output logic [reg_idx_w-1:0] mem_rd
);
    logic is_mem;
    logic writes_reg;

    assign is_mem     = (cur_rec.op == op_load) || (cur_rec.op == op_store);
    assign writes_reg = (cur_rec.op == op_alu) || (cur_rec.op == op_load) ||
                        (cur_rec.op == op_pass);

    // memory ops wait for the AXI port
    assign out_valid = cur_valid && (!is_mem || mem_done);
    assign advance   = out_valid && out_ready;

    assign out_rec.pc   = cur_rec.pc;
    assign out_rec.inst = cur_rec.inst;
    assign out_rec.op   = cur_rec.op;
    assign out_rec.rd   = cur_rec.rd;

    // write only in the transfer cycle, so a stall never writes twice
    assign gpr_wr.wen = advance && writes_reg;
    assign gpr_wr.rd  = cur_rec.rd;

    always_comb begin
        case (cur_rec.op)
            op_load: gpr_wr.value = load_value;
            // forwarded source matches the newest register value
            op_pass: gpr_wr.value = store_src;
            default: gpr_wr.value = cur_rec.alu_out;
        endcase
    end

    // hazard report for the stages upstream
    assign mem_busy_wr = cur_valid && writes_reg;
    assign mem_rd      = cur_rec.rd;

endmodule

/* testbench/axi_mem_model.sv */
// AXI4 slave memory for the memory stage testbench
// 64 beats of 64 bits, one transfer at a time, random ready and response delays
// contents start from an address-derived fill pattern
`timescale 1ns/1ns

module axi_mem_model
    import mem_stage_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  axi_addr_t       ar,
    input  logic            arvalid,
    output logic            arready,
    output axi_r_t          r,
    output logic            rvalid,
    input  logic            rready,
    input  axi_addr_t       aw,
    input  logic            awvalid,
    output logic            awready,
    input  axi_w_t          w,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      b_resp,
    output logic            bvalid,
    input  logic            bready
);
    localparam int mem_words = 64;

    logic [xlen-1:0] mem [0:mem_words-1];
    logic [31:0]     rnd;
    logic            rd_busy;
    logic            aw_got;
    logic            w_got;
    logic            b_busy;
    logic            r_done;
    logic            b_done;
    logic [5:0]      rd_idx;
    logic [5:0]      wr_idx;
    axi_w_t          w_hold;
    logic [1:0]      r_delay;
    logic [1:0]      b_delay;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // beat contents before any write, derived from the full byte address
    function automatic logic [xlen-1:0] fill_word(input logic [31:0] addr);
        return {addr ^ 32'h5a5a_c3c3, addr * 32'h9e37_79b1 + 32'd1};
    endfunction

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(i * 8);
        end
        rnd     = 32'hbeab;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        b_resp  = 2'b00;
    end

    always @(posedge clk) begin
        // handshakes as seen on this edge
        r_done = rvalid && rready;
        b_done = bvalid && bready;
        if (rst) begin
            rd_busy = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            b_busy  = 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_busy = 1'b1;
                rd_idx  = ar.addr[8:3];
                r_delay = rnd[4:3];
            end
            if (awvalid && awready) begin
                aw_got = 1'b1;
                wr_idx = aw.addr[8:3];
            end
            if (wvalid && wready) begin
                w_got  = 1'b1;
                w_hold = w;
            end
            if (r_done) begin
                rd_busy = 1'b0;
            end
            if (b_done) begin
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_busy = 1'b0;
            end
        end
        #1;
        rnd = xorshift(rnd);
        if (rst || r_done) begin
            rvalid = 1'b0;
        end
        if (rst || b_done) begin
            bvalid = 1'b0;
        end
        // read data after a random wait
        if (rd_busy && !rvalid) begin
            if (r_delay == 0) begin
                rvalid = 1'b1;
                r.data = mem[rd_idx];
                r.resp = 2'b00;
                r.last = 1'b1;
            end else begin
                r_delay = r_delay - 2'd1;
            end
        end
        // write lands once address and data are both in
        if (aw_got && w_got && !b_busy) begin
            for (int i = 0; i < strb_w; i++) begin
                if (w_hold.strb[i]) begin
                    mem[wr_idx][8*i +: 8] = w_hold.data[8*i +: 8];
                end
            end
            b_busy  = 1'b1;
            b_delay = rnd[6:5];
        end
        if (b_busy && !bvalid && !rst) begin
            if (b_delay == 0) begin
                bvalid = 1'b1;
            end else begin
                b_delay = b_delay - 2'd1;
            end
        end
        arready = !rst && !rd_busy && rnd[0];
        awready = !rst && !aw_got && rnd[1];
        wready  = !rst && !w_got && rnd[2];
    end

endmodule

/* testbench/tb_mem_stage.sv */
// testbench for the memory-access stage
// directed and random records, a shadow memory and a reference model of the
// stage; a monitor compares every write-back transfer, every AXI request
// and the interlock report
`timescale 1ns/1ns

module tb_mem_stage
    import mem_stage_pkg::*;
();
    localparam int wait_limit = 300;

    // one expected write-back transfer
    typedef struct packed {
        mem_wb_t               rec;
        logic                  wen;
        logic [xlen-1:0]       value;
        logic [axi_addr_w-1:0] addr;
    } expect_t;

    logic clk, rst, in_valid, in_ready, out_valid, out_ready, mem_busy_wr;
    ex_mem_t              in_rec;
    gpr_write_t           wb_fwd, gpr_wr;
    mem_wb_t              out_rec;
    logic [reg_idx_w-1:0] mem_rd;
    axi_addr_t            ar, aw;
    axi_r_t               r;
    axi_w_t               w;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready;
    logic bvalid, bready;
    logic [1:0]           b_resp;

    expect_t         exp_q[$];
    expect_t         head;
    axi_addr_t       req_exp;
    logic [xlen-1:0] shadow [0:63];
    logic [31:0]     stim_rnd, ready_rnd;
    logic [xlen-1:0] pc_next;
    int              checks, mismatches, failures;

    mem_stage dut (.*);

    axi_mem_model mem_model (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rnd = xorshift(stim_rnd);
        return stim_rnd;
    endfunction

    function automatic logic [xlen-1:0] fill_word(input logic [31:0] addr);
        return {addr ^ 32'h5a5a_c3c3, addr * 32'h9e37_79b1 + 32'd1};
    endfunction

    // reference model of write-back value per op, byte lanes and extension
    // worked out byte by byte on the shadow memory
    function automatic expect_t predict(input ex_mem_t rec);
        expect_t         e;
        logic [xlen-1:0] src;
        int              idx, off, nb;
        e.rec.pc   = rec.pc;
        e.rec.inst = rec.inst;
        e.rec.op   = rec.op;
        e.rec.rd   = rec.rd;
        e.wen      = (rec.op == op_alu) || (rec.op == op_load) || (rec.op == op_pass);
        e.value    = '0;
        // requests go out on the 8-byte beat that holds the access
        e.addr     = rec.alu_out[31:0] & 32'hffff_fff8;
        src = (wb_fwd.wen && wb_fwd.rd == rec.rs2 && rec.rs2 != 0) ? wb_fwd.value : rec.src2;
        idx = rec.alu_out[8:3];
        off = rec.alu_out[2:0];
        nb  = 1 << rec.funct3[1:0];
        case (rec.op)
            op_alu:  e.value = rec.alu_out;
            op_pass: e.value = src;
            op_store: begin
                for (int k = 0; k < nb; k++) begin
                    shadow[idx][8*(off+k) +: 8] = src[8*k +: 8];
                end
            end
            op_load: begin
                for (int k = 0; k < nb; k++) begin
                    e.value[8*k +: 8] = shadow[idx][8*(off+k) +: 8];
                end
                // signed loads copy the top loaded bit upward
                for (int b = 8 * nb; b < xlen; b++) begin
                    e.value[b] = !rec.funct3[2] && e.value[8*nb-1];
                end
            end
            default: e.value = '0;
        endcase
        return e;
    endfunction

    function automatic ex_mem_t make_record(input op_class_t op, input size_code f3,
                                            input logic [xlen-1:0] alu_out,
                                            input logic [4:0] rd, input logic [4:0] rs2,
                                            input logic [xlen-1:0] src2);
        ex_mem_t rec;
        rec.pc      = pc_next;
        rec.inst    = next_stim();
        rec.op      = op;
        rec.funct3  = f3;
        rec.rd      = rd;
        rec.rs2     = rs2;
        rec.alu_out = alu_out;
        rec.src2    = src2;
        pc_next     = pc_next + 4;
        return rec;
    endfunction

    function automatic ex_mem_t random_record();
        logic [31:0]     a, b;
        op_class_t       op;
        logic [1:0]      sz;
        logic [2:0]      off;
        logic [xlen-1:0] addr;
        a   = next_stim();
        b   = next_stim();
        op  = op_class_t'(a % 5);
        sz  = b[1:0];
        // aligned offset is always 0 for double-words
        off = b[4:2] & ~((3'd1 << sz) - 3'd1);
        if (op == op_load || op == op_store) begin
            addr = {55'd0, b[13:8], off};
        end else begin
            addr = {next_stim(), a};
        end
        return make_record(op, {b[5] && sz != 2'd3 && op == op_load, sz}, addr,
                           b[18:14], b[23:19], {next_stim(), next_stim()});
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // called 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_record(input ex_mem_t rec);
        int waited;
        in_rec   = rec;
        in_valid = 1'b1;
        waited   = 0;
        @(posedge clk);
        while (!in_ready && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!in_ready) begin
            report_failure("stage never accepted a record, in_ready stuck low");
            finish_run();
        end
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_failure("accepted records never left the stage");
            finish_run();
        end
    endtask

    // write-back stalls about one cycle in four
    initial begin
        ready_rnd = xorshift(32'hbeab);
        forever begin
            @(posedge clk);
            #1;
            ready_rnd = xorshift(ready_rnd);
            out_ready = (ready_rnd[1:0] != 2'b00);
        end
    end

    // monitor checks interlock, AXI requests, outgoing transfers and then
    // incoming records on pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].wen) begin
                check_value("mem_busy_wr", 1'b1, mem_busy_wr);
                check_value("mem_rd", exp_q[0].rec.rd, mem_rd);
            end else begin
                check_value("mem_busy_wr", 1'b0, mem_busy_wr);
            end
            // single-beat INCR request of 8 bytes on the record's beat address
            if (arvalid || awvalid || wvalid) begin
                if (exp_q.size() == 0) begin
                    report_failure("AXI request issued with no record in the stage");
                end else begin
                    req_exp.addr  = exp_q[0].addr;
                    req_exp.len   = 8'd0;
                    req_exp.size  = 3'd3;
                    req_exp.burst = 2'b01;
                    if (arvalid) begin
                        check_value("ar", req_exp, ar);
                    end
                    if (awvalid) begin
                        check_value("aw", req_exp, aw);
                    end
                    if (wvalid) begin
                        check_value("w.last", 1'b1, w.last);
                    end
                end
            end
            if (gpr_wr.wen && !(out_valid && out_ready)) begin
                report_failure("register write outside a write-back transfer");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("record left the stage although none was accepted");
                end else begin
                    head = exp_q.pop_front();
                    check_value("out_rec", head.rec, out_rec);
                    check_value("gpr_wr.wen", head.wen, gpr_wr.wen);
                    if (head.wen) begin
                        check_value("gpr_wr.rd", head.rec.rd, gpr_wr.rd);
                        check_value("gpr_wr.value", head.value, gpr_wr.value);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(predict(in_rec));
            end
        end
    end

    initial begin
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_rec     = '0;
        wb_fwd     = '0;
        out_ready  = 1'b0;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        stim_rnd   = 32'hbeab;
        pc_next    = 64'h0000_0000_8000_0000;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = fill_word(i * 8);
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        checks++;
        if (out_valid || gpr_wr.wen || arvalid || awvalid || wvalid || mem_busy_wr ||
            rready || bready || !in_ready) begin
            report_failure("outputs not in their reset state after reset");
        end

        // register-only ops, then the two classes that write nothing
        send_record(make_record(op_alu, 3'd0, 64'h0123_4567_89ab_cdef, 5'd3, 5'd0, '0));
        send_record(make_record(op_pass, 3'd0, '0, 5'd4, 5'd6, 64'hfedc_ba98_7654_3210));
        send_record(make_record(op_none, 3'd0, 64'h55, 5'd5, 5'd0, '0));
        send_record(make_record(op_store, 3'd3, 64'h100, 5'd7, 5'd8, 64'h1111_2222_3333_4444));

        // every size at every aligned offset read back signed and unsigned
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                addr = 64'((16 + sz) * 8 + off);
                data = {next_stim(), next_stim()};
                send_record(make_record(op_store, size_code'(sz), addr, 5'd1, 5'd2, data));
                send_record(make_record(op_load, size_code'(sz), addr, 5'd10, 5'd0, '0));
                if (sz < 3) begin
                    send_record(make_record(op_load, size_code'(sz + 4), addr, 5'd11, 5'd0, '0));
                end
            end
        end

        // store data forwarded from write-back but never from x0
        drain();
        wb_fwd = '{wen: 1'b1, rd: 5'd9, value: 64'hcafe_f00d_dead_beef};
        send_record(make_record(op_store, 3'd3, 64'h140, 5'd0, 5'd9, 64'h0bad_0bad_0bad_0bad));
        send_record(make_record(op_load, 3'd3, 64'h140, 5'd12, 5'd0, '0));
        drain();
        wb_fwd = '{wen: 1'b1, rd: 5'd0, value: 64'h7777_7777_7777_7777};
        send_record(make_record(op_store, 3'd3, 64'h148, 5'd0, 5'd0, 64'h0123_0123_0123_0123));
        send_record(make_record(op_load, 3'd3, 64'h148, 5'd13, 5'd0, '0));
        drain();
        wb_fwd = '0;

        // random mix under random back-pressure and memory delays
        repeat (300) begin
            send_record(random_record());
        end
        drain();
        finish_run();
    end

endmodule
